// ==== tests/renderer_testdata.txt ====
// Scenarios at 16 words each: scroll_x scroll_y, then per layer
// flags(bit0 enable, bit1 transparency) key palette offset_x offset_y data_offset
@000
0 0 0 0 0 0 0 0 0 0 0 0 0 0
@010
0 0 1 0 0 0 0 0 0 0 0 0 0 0
@020
0 0 1 0 0 0 0 0 3 EE 1 0 0 40
@030
1F5 3D 1 0 0 2 0 0 3 EE 1 0 0 40
// Tilemap, layer 0 then layer 1, eight tile indices per map row
@040
0 1 0 1 0 1 0 1 1 0 1 0 1 0 1 0
0 1 0 1 0 1 0 1 1 0 1 0 1 0 1 0
0 1 0 1 0 1 0 1 1 0 1 0 1 0 1 0
0 1 0 1 0 1 0 1 1 0 1 0 1 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// VRAM words: tile 0, tile 1, then the layer 1 tile at word 40
@0C0
1110 1312 1514 1716 1918 1B1A 1D1C 1F1E 2120 2322 2524 2726 2928 2B2A 2D2C 2F2E
3130 3332 3534 3736 3938 3B3A 3D3C 3F3E 4140 4342 4544 4746 4948 4B4A 4D4C 4F4E
5150 5352 5554 5756 5958 5B5A 5D5C 5F5E 6160 6362 6564 6766 6968 6B6A 6D6C 6F6E
7170 7372 7574 7776 7978 7B7A 7D7C 7F7E 8180 8382 8584 8786 8988 8B8A 8D8C 8F8E
EE90 EE92 EE94 EE96 99EE 9BEE 9DEE 9FEE EEA0 EEA2 EEA4 EEA6 A9EE ABEE ADEE AFEE
EEB0 EEB2 EEB4 EEB6 B9EE BBEE BDEE BFEE EEC0 EEC2 EEC4 EEC6 C9EE CBEE CDEE CFEE
// Expected frame pixels: scenario x y colour
@120
0 0 0 0
1 0 0 43EF
1 9 2 1879E
2 0 0 2426F
2 1 0 47EE
3 0 0 2F642
3 1 0 1F383

// ==== src.f ====
source/render_pkg.sv
source/delay_line.sv
source/scan_timing.sv
source/render_sequencer.sv
source/tile_fetch_pipe.sv
source/line_buffer.sv
source/scanout_stage.sv
source/renderer_top.sv
tests/renderer_tb.sv

// ==== Makefile ====
TOP := renderer_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/renderer_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the tile renderer. Models the tilemap, VRAM and palette,
// runs each scenario from the test data file for four frames and
// checks frames 2 and 3 pixel by pixel, plus blank and sync timing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module renderer_tb;
  parameter int H_VISIBLE    = 32;
  parameter int H_TOTAL      = 96;
  parameter int V_VISIBLE    = 8;
  parameter int V_TOTAL      = 10;
  parameter int NUM_LAYERS   = 2;
  parameter int MAP_TILES    = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_SCEN     = 4;
  localparam int NUM_SPOTS    = 7;
  localparam int FRAME_PIX    = H_VISIBLE * V_VISIBLE;
  localparam int WORLD        = MAP_TILES * 8;
  // Data file layout in 32-bit words.
  localparam int CFG_BASE  = 'h000;
  localparam int MAP_BASE  = 'h040;
  localparam int VRAM_BASE = 'h0C0;
  localparam int VRAM_LEN  = 96;
  localparam int SPOT_BASE = 'h120;
  // Four frames and a reset per scenario plus two lines of slack.
  localparam int CYCLE_LIMIT =
    NUM_SCEN * (4 * H_TOTAL * V_TOTAL + RESET_CYCLES + 2 * H_TOTAL);

  logic                                     clk;
  logic                                     reset;
  render_pkg::layer_cfg_t [NUM_LAYERS-1:0]  layers;
  render_pkg::scroll_t                      scroll;
  logic [6:0]                               map_addr;
  logic [15:0]                              map_data;
  logic [15:0]                              vram_addr;
  logic [15:0]                              vram_data;
  logic [9:0]                               pal_addr;
  render_pkg::rgb_t                         pal_data;
  render_pkg::rgb_t                         rgb;
  logic                                     blank;
  logic                                     h_sync;
  logic                                     v_sync;

  logic [31:0] data_words [0:'h13F];
  logic [15:0] map_mem [0:127];
  logic [15:0] vram_mem [0:255];
  logic [17:0] frame_got [0:FRAME_PIX-1];
  int          scenario;
  int          pix_count;
  int          h_low_run;
  int          v_low_run;
  int          cycles;
  int          errors;
  int          checks;

  renderer_top #(
    .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL), .V_VISIBLE(V_VISIBLE),
    .V_TOTAL(V_TOTAL), .NUM_LAYERS(NUM_LAYERS), .MAP_TILES(MAP_TILES)
  ) renderer_top_i (
    .clk(clk), .reset(reset), .layers(layers), .scroll(scroll),
    .map_addr(map_addr), .map_data(map_data), .vram_addr(vram_addr),
    .vram_data(vram_data), .pal_addr(pal_addr), .pal_data(pal_data),
    .rgb(rgb), .blank(blank), .h_sync(h_sync), .v_sync(v_sync)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Palette fill is unique per address.
  function automatic logic [17:0] pal_colour(input logic [9:0] a);
    return {a[7:0], ~a};
  endfunction

  // Unloaded VRAM reads as zero.
  function automatic logic [15:0] vram_word(input int a);
    return (a >= 0 && a < 256) ? vram_mem[a] : 16'h0000;
  endfunction

  // Expected colour of screen pixel (x, y) in the running scenario.
  // Layers are applied in ascending order.
  function automatic logic [17:0] expected_pixel(input int x, input int y);
    logic [17:0] colour;
    logic [15:0] word;
    logic [7:0]  pix;
    int          sbase;
    int          base;
    int          wx;
    int          wy;
    int          tile;
    colour = '0;
    sbase  = CFG_BASE + 16 * scenario;
    for (int l = 0; l < NUM_LAYERS; l++) begin
      base = sbase + 2 + 6 * l;
      if (data_words[base][0]) begin
        wx = x + int'(data_words[sbase][8:0]) - int'(data_words[base+3]);
        wy = y + int'(data_words[sbase+1][8:0]) - int'(data_words[base+4]);
        wx = ((wx % WORLD) + WORLD) % WORLD;
        wy = ((wy % WORLD) + WORLD) % WORLD;
        tile = map_mem[l * MAP_TILES * MAP_TILES + (wy / 8) * MAP_TILES + wx / 8];
        word = vram_word((int'(data_words[base+5]) + tile * 32 + (wy % 8) * 4
                          + (wx % 8) / 2) % 65536);
        pix = (wx % 2 == 1) ? word[15:8] : word[7:0];
        // Colour key hides the pixel only with transparency on.
        if (!(data_words[base][1] && pix == data_words[base+1][7:0])) begin
          colour = pal_colour({data_words[base+2][1:0], pix});
        end
      end
    end
    return colour;
  endfunction

  task automatic check_value(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_memories();
    for (int i = 0; i <= 'h13F; i++) begin
      data_words[i] = '0;
    end
    $readmemh("tests/renderer_testdata.txt", data_words);
    for (int i = 0; i < 128; i++) begin
      map_mem[i] = data_words[MAP_BASE + i][15:0];
    end
    for (int i = 0; i < 256; i++) begin
      vram_mem[i] = (i < VRAM_LEN) ? data_words[VRAM_BASE + i][15:0] : 16'h0;
    end
  endtask

  // Reset, load one configuration and run until frame 3 has been seen.
  task automatic run_scenario(input int s);
    int base;
    @(negedge clk);
    reset <= 1'b1;
    base = CFG_BASE + 16 * s;
    scroll.scroll_x <= data_words[base][8:0];
    scroll.scroll_y <= data_words[base+1][8:0];
    for (int l = 0; l < NUM_LAYERS; l++) begin
      layers[l].enable      <= data_words[base+2+6*l][0];
      layers[l].transp_en   <= data_words[base+2+6*l][1];
      layers[l].color_key   <= data_words[base+3+6*l][7:0];
      layers[l].palette     <= data_words[base+4+6*l][1:0];
      layers[l].offset_x    <= data_words[base+5+6*l][8:0];
      layers[l].offset_y    <= data_words[base+6+6*l][8:0];
      layers[l].data_offset <= data_words[base+7+6*l][15:0];
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset <= 1'b0;
    while (pix_count < 4 * FRAME_PIX) @(negedge clk);
  endtask

  // Hand-worked pixels of frame 3 from the data file.
  task automatic check_spots(input int s);
    int b;
    for (int k = 0; k < NUM_SPOTS; k++) begin
      b = SPOT_BASE + 4 * k;
      if (data_words[b] == s) begin
        check_value(frame_got[data_words[b+2] * H_VISIBLE + data_words[b+1]],
                    data_words[b+3], $sformatf("spot x=%0d y=%0d scenario %0d",
                    data_words[b+1], data_words[b+2], s));
      end
    end
  endtask

  // Output monitor samples away from the rising edge.
  always @(negedge clk) begin : monitor
    int idx;
    int x;
    int y;
    if (reset) begin
      pix_count = 0;
      h_low_run = 0;
      v_low_run = 0;
    end else begin
      if (!blank) begin
        idx = pix_count - 2 * FRAME_PIX;
        if (idx >= 0 && idx < 2 * FRAME_PIX) begin
          x = (idx % FRAME_PIX) % H_VISIBLE;
          y = (idx % FRAME_PIX) / H_VISIBLE;
          check_value(rgb, expected_pixel(x, y),
                      $sformatf("pixel x=%0d y=%0d", x, y));
          if (idx >= FRAME_PIX) begin
            frame_got[y * H_VISIBLE + x] = rgb;
          end
        end
        pix_count++;
      end else if (rgb != '0) begin
        check_value(rgb, 0, "rgb during blank");
      end
      // Pulse widths are checked when sync returns high.
      if (!h_sync) begin
        h_low_run++;
      end else if (h_low_run != 0) begin
        check_value(h_low_run, 4, "h_sync width");
        h_low_run = 0;
      end
      if (!v_sync) begin
        v_low_run++;
      end else if (v_low_run != 0) begin
        check_value(v_low_run, 4 * H_TOTAL, "v_sync width");
        v_low_run = 0;
      end
    end
  end

  // Synchronous memories with one clock of latency.
  always @(posedge clk) begin
    map_data  <= map_mem[map_addr];
    vram_data <= vram_word(int'(vram_addr));
    pal_data  <= pal_colour(pal_addr);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the frames did not complete within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    reset     = 1'b1;
    layers    = '0;
    scroll    = '0;
    map_data  = '0;
    vram_data = '0;
    pal_data  = '0;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    pix_count = 0;
    scenario  = 0;
    load_memories();
    for (int s = 0; s < NUM_SCEN; s++) begin
      scenario = s;
      run_scenario(s);
      check_spots(s);
    end
    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== source/renderer_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scanline tile renderer. Draws line y+1 into one buffer bank while
// line y is scanned out of the other. The three memories are external.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module renderer_top #(
  parameter int  H_VISIBLE  = 32,
  parameter int  H_TOTAL    = 96,
  parameter int  V_VISIBLE  = 8,
  parameter int  V_TOTAL    = 10,
  parameter int  NUM_LAYERS = 2,
  parameter int  MAP_TILES  = 8,
  localparam int LAYER_W    = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1,
  localparam int MAP_AW     = LAYER_W + 2 * $clog2(MAP_TILES)
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  render_pkg::layer_cfg_t [NUM_LAYERS-1:0]  layers,
  input  render_pkg::scroll_t                      scroll,
  output logic [MAP_AW-1:0]                        map_addr,
  input  logic [15:0]                              map_data,
  output logic [15:0]                              vram_addr,
  input  logic [15:0]                              vram_data,
  output logic [9:0]                               pal_addr,
  input  render_pkg::rgb_t                         pal_data,
  output render_pkg::rgb_t                         rgb,
  output logic                                     blank,
  output logic                                     h_sync,
  output logic                                     v_sync
);
  localparam int X_W = $clog2(H_VISIBLE);
  localparam int HW  = $clog2(H_TOTAL);
  localparam int VW  = $clog2(V_TOTAL);

  // Beam.
  logic [HW-1:0] h_pos;
  logic [VW-1:0] v_pos;
  logic          h_blank;
  logic          v_blank;
  logic          h_sync_raw;
  logic          v_sync_raw;
  logic          line_start;

  // Render side.
  logic                          draw_valid;
  logic [X_W-1:0]                render_x;
  logic [LAYER_W-1:0]            layer;
  logic [render_pkg::COORD_W-1:0] render_y;
  logic                          buf_wr;
  logic [X_W:0]                  buf_addr;
  render_pkg::rgb_t              buf_data;

  // Scanout side.
  logic                          rd;
  logic [X_W:0]                  rd_addr;
  render_pkg::rgb_t              rd_data;

  scan_timing #(
    .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
    .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL)
  ) scan_timing_i (
    .clk(clk), .reset(reset), .h_pos(h_pos), .v_pos(v_pos),
    .h_blank(h_blank), .v_blank(v_blank), .h_sync(h_sync_raw),
    .v_sync(v_sync_raw), .line_start(line_start)
  );

  render_sequencer #(
    .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL), .V_VISIBLE(V_VISIBLE),
    .V_TOTAL(V_TOTAL), .NUM_LAYERS(NUM_LAYERS)
  ) render_sequencer_i (
    .clk(clk), .reset(reset), .line_start(line_start), .h_pos(h_pos),
    .v_pos(v_pos), .layers(layers), .draw_valid(draw_valid),
    .render_x(render_x), .layer(layer), .render_y(render_y)
  );

  tile_fetch_pipe #(
    .NUM_LAYERS(NUM_LAYERS), .MAP_TILES(MAP_TILES), .H_VISIBLE(H_VISIBLE)
  ) tile_fetch_pipe_i (
    .clk(clk), .reset(reset), .draw_valid(draw_valid), .render_x(render_x),
    .render_y(render_y), .layer(layer), .layers(layers), .scroll(scroll),
    .map_addr(map_addr), .map_data(map_data), .vram_addr(vram_addr),
    .vram_data(vram_data), .pal_addr(pal_addr), .pal_data(pal_data),
    .buf_wr(buf_wr), .buf_addr(buf_addr), .buf_data(buf_data)
  );

  line_buffer #(
    .H_VISIBLE(H_VISIBLE)
  ) line_buffer_i (
    .clk(clk), .wr(buf_wr), .wr_addr(buf_addr), .wr_data(buf_data),
    .rd(rd), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  // Bank parity of the beam line, the opposite of the line being drawn.
  scanout_stage #(
    .H_VISIBLE(H_VISIBLE)
  ) scanout_stage_i (
    .clk(clk), .reset(reset), .h_pos(h_pos[X_W-1:0]), .v_pos(v_pos[0]),
    .h_blank(h_blank), .v_blank(v_blank), .h_sync(h_sync_raw),
    .v_sync(v_sync_raw), .rd(rd), .rd_addr(rd_addr), .rd_data(rd_data),
    .rgb(rgb), .blank(blank), .h_sync_out(h_sync), .v_sync_out(v_sync)
  );

endmodule

// ==== source/scanout_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads the finished line out of the buffer and registers the RGB.
// Sync and blank are delayed to line up with the colour.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scanout_stage #(
  parameter int  H_VISIBLE = 32,
  localparam int X_W       = $clog2(H_VISIBLE)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [X_W-1:0]   h_pos,
  // Line parity only, it picks the bank.
  input  logic             v_pos,
  input  logic             h_blank,
  input  logic             v_blank,
  input  logic             h_sync,
  input  logic             v_sync,
  output logic             rd,
  output logic [X_W:0]     rd_addr,
  input  render_pkg::rgb_t rd_data,
  output render_pkg::rgb_t rgb,
  output logic             blank,
  output logic             h_sync_out,
  output logic             v_sync_out
);
  logic       rd_valid;
  logic [2:0] active_q;

  assign rd      = !(h_blank || v_blank);
  assign rd_addr = {v_pos, h_pos};

  // Buffer data lands one clock after rd; black outside the picture.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rgb      <= '0;
    end else begin
      rd_valid <= rd;
      rgb      <= rd_valid ? rd_data : '0;
    end
  end

  // Delayed as active-high so a cleared line reads as idle.
  delay_line #(
    .WIDTH(3),
    .DELAY(render_pkg::SCAN_LATENCY)
  ) ctrl_delay (
    .clk   (clk),
    .reset (reset),
    .d     ({rd, ~h_sync, ~v_sync}),
    .q     (active_q)
  );

  assign blank      = ~active_q[2];
  assign h_sync_out = ~active_q[1];
  assign v_sync_out = ~active_q[0];

endmodule

// ==== source/line_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two banks of one line each. One port writes rendered pixels; the
// other reads for scanout and zeroes each entry as it goes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module line_buffer #(
  parameter int  H_VISIBLE = 32,
  localparam int X_W       = $clog2(H_VISIBLE)
) (
  input  logic             clk,
  input  logic             wr,
  input  logic [X_W:0]     wr_addr,
  input  render_pkg::rgb_t wr_data,
  input  logic             rd,
  input  logic [X_W:0]     rd_addr,
  output render_pkg::rgb_t rd_data
);
  // Top address bit picks the bank.
  render_pkg::rgb_t mem [2][H_VISIBLE];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_addr[X_W]][wr_addr[X_W-1:0]] <= wr_data;
    end
    if (rd) begin
      rd_data <= mem[rd_addr[X_W]][rd_addr[X_W-1:0]];
      // Leave background zero for the next line in this bank.
      mem[rd_addr[X_W]][rd_addr[X_W-1:0]] <= '0;
    end
  end

  // Render and scanout must always work in opposite banks.
  no_write_clear_clash: assert property (@(posedge clk)
    !(wr && rd && (wr_addr == rd_addr)));

endmodule

// ==== source/tile_fetch_pipe.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage tile pixel fetch. Turns a render position into tilemap,
// VRAM and palette reads and a line-buffer write FETCH_LATENCY later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tile_fetch_pipe #(
  parameter int  NUM_LAYERS = 2,
  parameter int  MAP_TILES  = 8,
  parameter int  H_VISIBLE  = 32,
  localparam int LAYER_W    = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1,
  localparam int MAP_W      = $clog2(MAP_TILES),
  localparam int X_W        = $clog2(H_VISIBLE)
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     draw_valid,
  input  logic [X_W-1:0]                           render_x,
  input  logic [render_pkg::COORD_W-1:0]           render_y,
  input  logic [LAYER_W-1:0]                       layer,
  input  render_pkg::layer_cfg_t [NUM_LAYERS-1:0]  layers,
  input  render_pkg::scroll_t                      scroll,
  output logic [LAYER_W+2*MAP_W-1:0]               map_addr,
  input  logic [15:0]                              map_data,
  output logic [15:0]                              vram_addr,
  input  logic [15:0]                              vram_data,
  output logic [9:0]                               pal_addr,
  input  render_pkg::rgb_t                         pal_data,
  output logic                                     buf_wr,
  output logic [X_W:0]                             buf_addr,
  output render_pkg::rgb_t                         buf_data
);
  localparam int TS = render_pkg::TILE_SHIFT;
  localparam int CW = render_pkg::COORD_W;

  render_pkg::layer_cfg_t cfg;
  logic [CW-1:0]          world_x;
  logic [CW-1:0]          world_y;
  logic [TS-1:0]          s1_row;
  logic [TS-1:0]          s1_col;
  logic [15:0]            s1_offset;
  logic                   s2_col0;
  logic                   s2_valid;
  logic                   s2_transp;
  logic [7:0]             s2_key;
  logic [1:0]             s2_palette;
  logic [7:0]             s2_pixel;
  logic                   s2_wr;

  // Stage 0: scroll into world space and address the tilemap.
  assign cfg     = layers[layer];
  assign world_x = CW'(render_x) + scroll.scroll_x - cfg.offset_x;
  assign world_y = render_y + scroll.scroll_y - cfg.offset_y;
  // Map position wraps at the map edge by truncation.
  assign map_addr = {layer, world_y[TS +: MAP_W], world_x[TS +: MAP_W]};

  // Position inside the tile rides along with the reads.
  always_ff @(posedge clk) begin
    s1_row    <= world_y[TS-1:0];
    s1_col    <= world_x[TS-1:0];
    s1_offset <= cfg.data_offset;
    s2_col0   <= s1_col[0];
  end

  // Stage 1: tile index to VRAM word.
  // 32 words per tile, 4 words per tile row, 2 pixels per word.
  assign vram_addr = s1_offset + (map_data << (2 * TS - 1))
                   + 16'({s1_row, s1_col[TS-1:1]});

  // Valid, key test and palette number, aligned to stage 2.
  delay_line #(
    .WIDTH(12),
    .DELAY(render_pkg::FETCH_LATENCY - 1)
  ) qual_delay (
    .clk   (clk),
    .reset (reset),
    .d     ({draw_valid, cfg.transp_en, cfg.color_key, cfg.palette}),
    .q     ({s2_valid, s2_transp, s2_key, s2_palette})
  );

  // Stage 2: pick the pixel byte and look up its colour.
  // Even columns sit in the low byte.
  assign s2_pixel = s2_col0 ? vram_data[15:8] : vram_data[7:0];
  assign pal_addr = {s2_palette, s2_pixel};
  // Colour-key hit means a see-through pixel.
  assign s2_wr = s2_valid && !(s2_transp && (s2_pixel == s2_key));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buf_wr <= 1'b0;
    end else begin
      buf_wr <= s2_wr;
    end
  end

  // Stage 3: palette colour straight into the buffer.
  // Bank comes from the parity of the line being drawn.
  delay_line #(
    .WIDTH(X_W + 1),
    .DELAY(render_pkg::FETCH_LATENCY)
  ) addr_delay (
    .clk   (clk),
    .reset (reset),
    .d     ({render_y[0], render_x}),
    .q     (buf_addr)
  );

  assign buf_data = pal_data;

endmodule

// ==== source/render_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Walks the tile layers once per line, lowest first, and steps the
// render x position across the next visible line for the fetch pipe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module render_sequencer #(
  parameter int  H_VISIBLE  = 32,
  parameter int  H_TOTAL    = 96,
  parameter int  V_VISIBLE  = 8,
  parameter int  V_TOTAL    = 10,
  parameter int  NUM_LAYERS = 2,
  localparam int HW         = $clog2(H_TOTAL),
  localparam int VW         = $clog2(V_TOTAL),
  localparam int X_W        = $clog2(H_VISIBLE),
  localparam int LAYER_W    = (NUM_LAYERS > 1) ? $clog2(NUM_LAYERS) : 1
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     line_start,
  input  logic [HW-1:0]                            h_pos,
  input  logic [VW-1:0]                            v_pos,
  input  render_pkg::layer_cfg_t [NUM_LAYERS-1:0]  layers,
  output logic                                     draw_valid,
  output logic [X_W-1:0]                           render_x,
  output logic [LAYER_W-1:0]                       layer,
  output logic [render_pkg::COORD_W-1:0]           render_y
);
  // Layer counter must also hold the "all done" value.
  localparam int CNT_W = $clog2(NUM_LAYERS + 1);

  localparam logic [HW-1:0]    H_LAST = HW'(H_TOTAL - 1);
  localparam logic [VW-1:0]    V_LAST = VW'(V_TOTAL - 1);
  localparam logic [VW-1:0]    V_VIS  = VW'(V_VISIBLE);
  localparam logic [X_W-1:0]   X_LAST = X_W'(H_VISIBLE - 1);
  localparam logic [CNT_W-1:0] L_DONE = CNT_W'(NUM_LAYERS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_DECIDE,
    S_DRAW
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] layer_cnt;
  logic [VW-1:0]    next_line;

  // Line after the beam, wrapping at the end of the frame.
  assign next_line  = (v_pos == V_LAST) ? '0 : v_pos + 1'b1;
  assign render_y   = render_pkg::COORD_W'(next_line);
  assign layer      = layer_cnt[LAYER_W-1:0];
  assign draw_valid = (state == S_DRAW);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_IDLE;
      layer_cnt <= '0;
      render_x  <= '0;
    end else if (state != S_IDLE && h_pos == H_LAST) begin
      // Out of time for this line, drop whatever is left.
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (line_start && next_line < V_VIS) begin
            state     <= S_DECIDE;
            layer_cnt <= '0;
          end
        end
        S_DECIDE: begin
          if (layer_cnt == L_DONE) begin
            state <= S_IDLE;
          end else if (layers[layer].enable) begin
            state    <= S_DRAW;
            render_x <= '0;
          end else begin
            // Disabled layer, skip to the next one.
            layer_cnt <= layer_cnt + 1'b1;
          end
        end
        S_DRAW: begin
          if (render_x == X_LAST) begin
            state     <= S_DECIDE;
            layer_cnt <= layer_cnt + 1'b1;
          end else begin
            render_x <= render_x + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // A layer draw is always entered through a decide clock.
  draw_after_decide: assert property (@(posedge clk) disable iff (reset)
    $rose(draw_valid) |-> $past(state) == S_DECIDE);

endmodule

// ==== source/scan_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beam position counters for the display. Gives blank, active-low
// sync and a line-start pulse to the render and scanout stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scan_timing #(
  parameter int  H_VISIBLE = 32,
  parameter int  H_TOTAL   = 96,
  parameter int  V_VISIBLE = 8,
  parameter int  V_TOTAL   = 10,
  localparam int HW        = $clog2(H_TOTAL),
  localparam int VW        = $clog2(V_TOTAL)
) (
  input  logic          clk,
  input  logic          reset,
  output logic [HW-1:0] h_pos,
  output logic [VW-1:0] v_pos,
  output logic          h_blank,
  output logic          v_blank,
  output logic          h_sync,
  output logic          v_sync,
  output logic          line_start
);
  localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
  localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);
  localparam logic [HW-1:0] H_VIS  = HW'(H_VISIBLE);
  localparam logic [VW-1:0] V_VIS  = VW'(V_VISIBLE);
  // Sync occupies the last four counts of each period.
  localparam logic [HW-1:0] H_SYNC = HW'(H_TOTAL - 4);
  localparam logic [VW-1:0] V_SYNC = VW'(V_TOTAL - 4);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (h_pos == H_LAST) begin
      h_pos <= '0;
      // Line wraps, frame may wrap too.
      v_pos <= (v_pos == V_LAST) ? '0 : v_pos + 1'b1;
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  assign h_blank    = (h_pos >= H_VIS);
  assign v_blank    = (v_pos >= V_VIS);
  assign h_sync     = !(h_pos >= H_SYNC);
  assign v_sync     = !(v_pos >= V_SYNC);
  assign line_start = (h_pos == '0);

  h_pos_in_range: assert property (@(posedge clk) disable iff (reset)
    h_pos < H_TOTAL);

endmodule

// ==== source/delay_line.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset-cleared shift register of DELAY stages. Keeps side values in
// step with a pipeline of the same depth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module delay_line #(
  parameter int WIDTH = 1,
  parameter int DELAY = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);
  logic [WIDTH-1:0] stage [DELAY];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DELAY; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      // Each stage takes the value of the one before it.
      for (int i = 1; i < DELAY; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DELAY-1];

endmodule

// ==== source/render_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared colour, layer and scroll types for the tile renderer, and
// the fixed latencies of its pipelines. Referenced by scoped name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package render_pkg;

  // World coordinates wrap on a 512-pixel square.
  localparam int COORD_W = 9;

  // Tiles are (1 << TILE_SHIFT) pixels on a side.
  localparam int TILE_SHIFT = 3;

  // Render x to line-buffer write.
  // Map read, VRAM read and palette read, one clock each.
  localparam int FETCH_LATENCY = 3;

  // Beam position to RGB pin.
  // Buffer read plus the output register.
  localparam int SCAN_LATENCY = 2;

  // 18-bit colour, six bits per channel.
  typedef struct packed {
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } rgb_t;

  // Per-layer configuration.
  // data_offset is a VRAM word address.
  typedef struct packed {
    logic               enable;
    logic               transp_en;
    logic [7:0]         color_key;
    logic [1:0]         palette;
    logic [COORD_W-1:0] offset_x;
    logic [COORD_W-1:0] offset_y;
    logic [15:0]        data_offset;
  } layer_cfg_t;

  // World scroll, shared by all layers.
  typedef struct packed {
    logic [COORD_W-1:0] scroll_x;
    logic [COORD_W-1:0] scroll_y;
  } scroll_t;

endpackage
